// File: src/spu_pkg.sv
`default_nettype none

// sprite unit shared constants and types
package spu_pkg;

	// --------------------
	// sprite file layout
	localparam int sprite_count = 32;	// descriptors per line walk
	localparam int sprite_regs = 8;		// regs per descriptor, addr = num*8 + reg

	// reg0  x low
	// reg1  x[8] in bit 7, width in words in 6:0
	// reg2  y low
	// reg3  y[8] in bit 7, height in lines in 6:0
	// reg4  mode in 1:0, palette base in 7:2
	// reg5..reg7  word address 7:0, 15:8, 20:16

	typedef enum logic [1:0]
	{
		mode_off = 2'd0,	// sprite skipped
		mode_4c  = 2'd1,	// 8 px per word, 2-bit index
		mode_16c = 2'd2,	// 4 px per word, 4-bit index
		mode_tc  = 2'd3		// 2 px per word, byte per px
	} spr_mode_t;

	// --------------------
	// palette and line buffer
	localparam int pal_trans_bit = 7;	// palette entry transparent flag
	localparam int line_entry_w = 7;	// valid + 6-bit colour

	typedef logic [line_entry_w-1:0] line_entry_t;

	// --------------------
	// memory side
	localparam int mem_addr_w = 21;		// word address
	localparam int mem_data_w = 16;
	localparam int offs_w = 14;			// per-sprite row offset, in words

	typedef logic [offs_w-1:0] offs_t;

	localparam int scan_div = 4;		// clocks per scanned pixel

endpackage

`default_nettype wire

// File: src/spu_ram.sv
`timescale 1ns/1ps
`default_nettype none

// simple dual port ram, one write port and one registered read port
module spu_ram
#(
	parameter type data_t = logic [7:0],
	parameter int depth = 256
)(
	input wire clk,

	input wire we,
	input wire [$clog2(depth)-1:0] waddr,
	input wire data_t wdata,

	input wire [$clog2(depth)-1:0] raddr,
	output data_t rdata
);

	// power-up contents all zero
	// sprites start off and the line banks start empty
	data_t mem [depth] = '{default: '0};

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];	// data one clock after the address
	end

endmodule

`default_nettype wire

// File: src/sprite_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// double line buffer
// one bank takes the engine's draw writes, the other is scanned out and wiped
module sprite_line_buffer
	import spu_pkg::*;
#(
	parameter int line_pixels = 360
)(
	input wire clk,
	input wire line_start,
	input wire bank,		// bank being drawn this line

	input wire draw_we,
	input wire [$clog2(line_pixels)-1:0] draw_x,
	input wire line_entry_t draw_entry,

	output logic [5:0] pix_color,
	output logic pix_valid,
	output logic [$clog2(line_pixels)-1:0] pix_x
);

	localparam int x_w = $clog2(line_pixels);
	localparam int line_depth = 2 ** x_w;
	localparam int phase_w = $clog2(scan_div);

	logic [phase_w-1:0] phase;	// position inside one scanned pixel
	logic [x_w-1:0] scan_x;
	logic scan_on;
	logic clr_we;
	line_entry_t rd [2];
	line_entry_t scan_rd;

	// --------------------
	// banks
	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		logic drawn;

		assign drawn = (bank == 1'(b));

		spu_ram #(
			.data_t (line_entry_t),
			.depth  (line_depth)
		) u_ram (
			.clk   (clk),
			.we    (drawn ? draw_we : clr_we),
			.waddr (drawn ? draw_x : scan_x),
			.wdata (drawn ? draw_entry : line_entry_t'('0)),	// scan side writes zeros
			.raddr (scan_x),
			.rdata (rd[b])
		);
	end

	assign scan_rd = rd[!bank];		// last line's bank
	assign clr_we = scan_on && (phase == phase_w'(1));	// wipe right after the pixel latch

	// --------------------
	// scan and clear
	always_ff @(posedge clk or posedge line_start)
		if (line_start)
		begin
			phase <= '0;
			scan_x <= '0;
			scan_on <= 1'b1;
			pix_valid <= 1'b0;
		end
		else
		begin
			if (phase == phase_w'(scan_div - 1))
				phase <= '0;
			else
				phase <= phase + phase_w'(1);

			if (phase == '0)
				pix_valid <= scan_on && scan_rd[line_entry_w-1];	// entry present

			if (scan_on && phase == phase_w'(1))
			begin
				if (scan_x == x_w'(line_pixels - 1))
					scan_on <= 1'b0;	// whole line done
				else
					scan_x <= scan_x + x_w'(1);
			end
		end

	// pixel payload, no reset
	always_ff @(posedge clk)
		if (scan_on && phase == '0)
		begin
			pix_color <= scan_rd[5:0];
			pix_x <= scan_x;
		end

	// the engine must clip before writing
	a_draw_in_line: assert property (@(posedge clk) disable iff (line_start)
		draw_we |-> draw_x < line_pixels);

endmodule

`default_nettype wire

// File: src/sprite_fetch.sv
`timescale 1ns/1ps
`default_nettype none

// single word prefetcher on the four-phase memory handshake
module sprite_fetch
	import spu_pkg::*;
(
	input wire clk,
	input wire line_start,

	input wire fetch_start,
	input wire [mem_addr_w-1:0] fetch_addr,
	output logic word_valid,
	output logic [mem_data_w-1:0] word_data,
	input wire word_take,

	output logic mem_req,
	output logic [mem_addr_w-1:0] mem_addr,
	input wire mem_ack,
	input wire [mem_data_w-1:0] mem_data
);

	typedef enum logic [1:0]
	{
		f_idle,		// nothing held, nothing open
		f_req,		// req high, waiting for ack
		f_drop,		// data taken, waiting for ack low
		f_full		// word held for the engine
	} fstate_t;

	fstate_t state;

	always_ff @(posedge clk or posedge line_start)
		if (line_start)
			state <= f_idle;
		else
			case (state)
			f_idle:
				if (fetch_start)
					state <= f_req;
			f_req:
				if (mem_ack)
					state <= f_drop;	// req falls here
			f_drop:
				if (!mem_ack)
					state <= f_full;	// handshake closed, next one may start
			f_full:
				if (word_take)
					state <= f_idle;
			default:
				state <= f_idle;
			endcase

	// address and data, no reset
	always_ff @(posedge clk)
	begin
		if (state == f_idle && fetch_start)
			mem_addr <= fetch_addr;		// stable for the whole request
		if (state == f_req && mem_ack)
			word_data <= mem_data;
	end

	assign mem_req = (state == f_req);
	assign word_valid = (state == f_full);

	// engine asks again only after it took the held word
	a_fetch_when_idle: assert property (@(posedge clk) disable iff (line_start)
		fetch_start |-> state == f_idle);

endmodule

`default_nettype wire

// File: src/sprite_engine.sv
`timescale 1ns/1ps
`default_nettype none

// per-line sprite walk
// reads descriptors, fetches visible rows, unpacks pixels into the draw bank
module sprite_engine
	import spu_pkg::*;
#(
	parameter int line_pixels = 360
)(
	input wire clk,
	input wire line_start,
	input wire [8:0] vline,

	output logic [7:0] sf_ra,
	input wire [7:0] sf_rd,

	output logic [7:0] pal_ra,
	input wire [7:0] pal_rd,

	output logic [$clog2(sprite_count)-1:0] offs_wa,
	output logic offs_we,
	output offs_t offs_wd,
	input wire offs_t offs_rd,
	output logic [$clog2(sprite_count)-1:0] offs_ra,

	output logic fetch_start,
	output logic [mem_addr_w-1:0] fetch_addr,
	input wire word_valid,
	input wire [mem_data_w-1:0] word_data,
	output logic word_take,

	output logic draw_we,
	output logic [$clog2(line_pixels)-1:0] draw_x,
	output line_entry_t draw_entry
);

	localparam int num_w = $clog2(sprite_count);
	localparam int reg_w = $clog2(sprite_regs);
	localparam int x_w = $clog2(line_pixels);

	// st_rN presents a reg address, the next state takes its data
	typedef enum logic [3:0]
	{
		st_r4, st_r2, st_r3, st_vis, st_r5, st_r6, st_r7, st_r0, st_r1,
		st_wait, st_pix, st_next, st_halt
	} state_t;

	state_t state;
	logic [num_w-1:0] num;			// current sprite
	spr_mode_t mode;
	logic [5:0] pal_base;
	logic [7:0] y_lo;
	logic first_line;				// vline is the sprite's top row
	logic [mem_addr_w-1:0] base_addr;
	offs_t offs;					// word offset of the next fetch
	logic [8:0] x_pos;
	logic [6:0] words_left;
	logic [3:0] pix_left;
	logic [9:0] x_cnt;				// pixels drawn on this row
	logic [mem_data_w-1:0] shreg;	// word being unpacked, msb first
	logic pf_pending;				// prefetch still to be issued

	// draw stage, one clock behind the palette address
	logic p_valid;
	logic [x_w-1:0] p_x;
	logic p_tc;
	logic p_opaque;
	logic [5:0] p_col;

	logic [reg_w-1:0] reg_sel;
	logic [8:0] y_full;
	logic [9:0] y_end;
	logic spr_vis;
	logic [mem_addr_w-1:0] word_addr;
	logic [3:0] pix_per_word;
	logic [10:0] pix_sum;

	// --------------------
	// descriptor addressing
	always_comb
		case (state)
		st_r2: reg_sel = reg_w'(2);
		st_r3: reg_sel = reg_w'(3);
		st_vis: reg_sel = reg_w'(5);
		st_r5: reg_sel = reg_w'(6);
		st_r6: reg_sel = reg_w'(7);
		st_r7: reg_sel = reg_w'(0);
		st_r0: reg_sel = reg_w'(1);
		default: reg_sel = reg_w'(4);	// mode reg opens every sprite
		endcase

	assign sf_ra = {num, reg_sel};
	assign offs_ra = num;
	assign offs_wa = num;

	assign y_full = {sf_rd[7], y_lo};	// valid in st_vis
	assign y_end = {1'b0, y_full} + {3'b0, sf_rd[6:0]};
	assign spr_vis = ({1'b0, vline} >= {1'b0, y_full}) && ({1'b0, vline} < y_end);
	assign word_addr = base_addr + mem_addr_w'(offs);
	assign pix_sum = {2'b0, x_pos} + {1'b0, x_cnt};

	always_comb
		case (mode)
		mode_4c: pix_per_word = 4'd8;
		mode_16c: pix_per_word = 4'd4;
		default: pix_per_word = 4'd2;
		endcase

	// base keeps its top bits, pixel index fills the rest
	assign pal_ra = (mode == mode_4c) ? {pal_base, shreg[15:14]}
		: {pal_base[5:2], shreg[15:12]};

	// --------------------
	// main fsm
	always_ff @(posedge clk or posedge line_start)
		if (line_start)
		begin
			state <= st_r4;
			num <= '0;
			fetch_start <= 1'b0;
			fetch_addr <= '0;
			word_take <= 1'b0;
			offs_we <= 1'b0;
			offs_wd <= '0;
			offs <= '0;
			p_valid <= 1'b0;
			pf_pending <= 1'b0;
			words_left <= '0;
			pix_left <= '0;
			x_cnt <= '0;
			mode <= mode_off;
			pal_base <= '0;
			y_lo <= '0;
			first_line <= 1'b0;
			base_addr <= '0;
			x_pos <= '0;
			shreg <= '0;
		end
		else
		begin
			fetch_start <= 1'b0;	// strobes
			word_take <= 1'b0;
			offs_we <= 1'b0;
			p_valid <= 1'b0;

			case (state)
			st_r4:
				state <= st_r2;
			st_r2:
				if (sf_rd[1:0] == mode_off)
					state <= st_next;
				else
				begin
					mode <= spr_mode_t'(sf_rd[1:0]);
					pal_base <= sf_rd[7:2];
					state <= st_r3;
				end
			st_r3:
			begin
				y_lo <= sf_rd;
				state <= st_vis;
			end
			st_vis:
			begin
				first_line <= (vline == y_full);
				state <= spr_vis ? st_r5 : st_next;
			end
			st_r5:
			begin
				base_addr[7:0] <= sf_rd;
				offs <= first_line ? '0 : offs_rd;	// top row restarts at 0
				state <= st_r6;
			end
			st_r6:
			begin
				base_addr[15:8] <= sf_rd;
				state <= st_r7;
			end
			st_r7:
			begin
				base_addr[20:16] <= sf_rd[4:0];
				state <= st_r0;
			end
			st_r0:
			begin
				x_pos[7:0] <= sf_rd;
				state <= st_r1;
			end
			st_r1:
			begin
				x_pos[8] <= sf_rd[7];
				if (sf_rd[6:0] == 7'd0)
					state <= st_next;	// zero width, nothing to draw
				else
				begin
					fetch_start <= 1'b1;	// first word of the row
					fetch_addr <= word_addr;
					offs <= offs + offs_t'(1);
					offs_we <= 1'b1;		// next line's row
					offs_wd <= offs + offs_t'(sf_rd[6:0]);
					words_left <= sf_rd[6:0];
					x_cnt <= '0;
					state <= st_wait;
				end
			end
			st_wait:
				if (word_valid)
				begin
					word_take <= 1'b1;
					shreg <= word_data;
					words_left <= words_left - 7'd1;
					pf_pending <= (words_left != 7'd1);
					pix_left <= pix_per_word;
					state <= st_pix;
				end
			st_pix:
			begin
				// fetcher is idle again one clock after the take
				if (pf_pending)
				begin
					fetch_start <= 1'b1;
					fetch_addr <= word_addr;
					offs <= offs + offs_t'(1);
					pf_pending <= 1'b0;
				end

				p_valid <= (pix_sum < 11'(line_pixels));	// clip at line end
				x_cnt <= x_cnt + 10'd1;
				pix_left <= pix_left - 4'd1;

				case (mode)
				mode_4c: shreg <= {shreg[13:0], 2'b0};
				mode_16c: shreg <= {shreg[11:0], 4'b0};
				default: shreg <= {shreg[7:0], 8'b0};
				endcase

				if (pix_left == 4'd1)
					state <= (words_left == 7'd0) ? st_next : st_wait;
			end
			st_next:
				if (num == num_w'(sprite_count - 1))
					state <= st_halt;
				else
				begin
					num <= num + num_w'(1);
					state <= st_r4;
				end
			st_halt:
				state <= st_halt;	// until next line_start
			default:
				state <= st_halt;
			endcase
		end

	// --------------------
	// draw stage, palette data arrives here
	always_ff @(posedge clk)
	begin
		p_x <= pix_sum[x_w-1:0];
		p_tc <= (mode == mode_tc);
		p_opaque <= shreg[15];		// true-colour opaque flag
		p_col <= shreg[13:8];
	end

	assign draw_we = p_valid && (p_tc ? p_opaque : !pal_rd[pal_trans_bit]);
	assign draw_x = p_x;
	assign draw_entry = {1'b1, p_tc ? p_col : pal_rd[5:0]};

	// halted engine stays put and silent until the next line
	a_halt_holds: assert property (@(posedge clk) disable iff (line_start)
		state == st_halt |=> state == st_halt && !fetch_start && !word_take
			&& !offs_we && !draw_we);

endmodule

`default_nettype wire

// File: src/sprite_unit.sv
`timescale 1ns/1ps
`default_nettype none

// sprite unit top
module sprite_unit
	import spu_pkg::*;
#(
	parameter int line_pixels = 360
)(
	input wire clk,
	input wire line_start,
	input wire frame_start,

	input wire host_we,
	input wire host_sel,		// 0 sprite file, 1 palette
	input wire [7:0] host_addr,
	input wire [7:0] host_data,

	output logic mem_req,
	output logic [mem_addr_w-1:0] mem_addr,
	input wire mem_ack,
	input wire [mem_data_w-1:0] mem_data,

	output logic [5:0] pix_color,
	output logic pix_valid,
	output logic [$clog2(line_pixels)-1:0] pix_x
);

	localparam int num_w = $clog2(sprite_count);
	localparam int x_w = $clog2(line_pixels);

	// survive line_start, power up at zero
	logic [8:0] vline = '0;
	logic [8:0] vline_nxt = '0;	// next line number, frozen during line_start
	logic bank = 1'b0;
	logic bank_nxt = 1'b0;

	logic sf_we, pal_we;
	logic [7:0] sf_ra, sf_rd, pal_ra, pal_rd;
	logic [num_w-1:0] offs_wa, offs_ra;
	logic offs_we;
	offs_t offs_wd, offs_rd;
	logic fetch_start, word_valid, word_take;
	logic [mem_addr_w-1:0] fetch_addr;
	logic [mem_data_w-1:0] word_data;
	logic draw_we;
	logic [x_w-1:0] draw_x;
	line_entry_t draw_entry;

	// --------------------
	// line counter and bank
	// reloaded on every edge while line_start is high, same value each time
	always_ff @(posedge clk or posedge line_start)
		if (line_start)
		begin
			vline <= frame_start ? '0 : vline_nxt;
			bank <= bank_nxt;	// swap draw and scan banks
		end
		else
		begin
			vline_nxt <= vline + 9'd1;
			bank_nxt <= ~bank;
		end

	// host write decode
	assign sf_we = host_we && !host_sel;
	assign pal_we = host_we && host_sel;

	// --------------------
	// rams
	spu_ram #(.data_t(logic [7:0]), .depth(sprite_count * sprite_regs)) u_sfile (
		.clk   (clk),
		.we    (sf_we),
		.waddr (host_addr),
		.wdata (host_data),
		.raddr (sf_ra),
		.rdata (sf_rd)
	);

	spu_ram #(.data_t(logic [7:0]), .depth(256)) u_palette (
		.clk   (clk),
		.we    (pal_we),
		.waddr (host_addr),
		.wdata (host_data),
		.raddr (pal_ra),
		.rdata (pal_rd)
	);

	spu_ram #(.data_t(offs_t), .depth(sprite_count)) u_offs (
		.clk   (clk),
		.we    (offs_we),
		.waddr (offs_wa),
		.wdata (offs_wd),
		.raddr (offs_ra),
		.rdata (offs_rd)
	);

	// --------------------
	// datapath
	sprite_engine #(.line_pixels(line_pixels)) u_engine (
		.clk         (clk),
		.line_start  (line_start),
		.vline       (vline),
		.sf_ra       (sf_ra),
		.sf_rd       (sf_rd),
		.pal_ra      (pal_ra),
		.pal_rd      (pal_rd),
		.offs_wa     (offs_wa),
		.offs_we     (offs_we),
		.offs_wd     (offs_wd),
		.offs_rd     (offs_rd),
		.offs_ra     (offs_ra),
		.fetch_start (fetch_start),
		.fetch_addr  (fetch_addr),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_take   (word_take),
		.draw_we     (draw_we),
		.draw_x      (draw_x),
		.draw_entry  (draw_entry)
	);

	sprite_fetch u_fetch (
		.clk         (clk),
		.line_start  (line_start),
		.fetch_start (fetch_start),
		.fetch_addr  (fetch_addr),
		.word_valid  (word_valid),
		.word_data   (word_data),
		.word_take   (word_take),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_ack     (mem_ack),
		.mem_data    (mem_data)
	);

	sprite_line_buffer #(.line_pixels(line_pixels)) u_lbuf (
		.clk        (clk),
		.line_start (line_start),
		.bank       (bank),
		.draw_we    (draw_we),
		.draw_x     (draw_x),
		.draw_entry (draw_entry),
		.pix_color  (pix_color),
		.pix_valid  (pix_valid),
		.pix_x      (pix_x)
	);

endmodule

`default_nettype wire

// File: tests/sprite_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// word memory behind the four-phase handshake
// contents are a fixed function of the address, ack comes after a random delay
module sprite_mem_model
(
	input wire clk,
	input wire mem_req,
	input wire [20:0] mem_addr,
	output logic mem_ack,
	output logic [15:0] mem_data
);

	integer seed = 32'hf77b;
	logic [2:0] wait_cnt;
	logic armed;			// delay drawn for the open request

	initial
	begin
		mem_ack = 1'b0;
		mem_data = '0;
		wait_cnt = '0;
		armed = 1'b0;
	end

	// responses change on the falling edge only
	always @(negedge clk)
		if (!mem_req)
		begin
			armed <= 1'b0;
			mem_ack <= 1'b0;	// closes the handshake
		end
		else if (!mem_ack)
		begin
			if (!armed)
			begin
				wait_cnt <= 3'($random(seed) & 7);	// 0 to 7 clocks
				armed <= 1'b1;
			end
			else if (wait_cnt == 3'd0)
			begin
				mem_ack <= 1'b1;
				mem_data <= mem_addr[15:0] ^ 16'h5a3c;
			end
			else
				wait_cnt <= wait_cnt - 3'd1;
		end

endmodule

`default_nettype wire

// File: tests/tb_sprite_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_unit;

	localparam int line_pixels = 360;

	logic clk = 1'b0;
	logic line_start, frame_start;
	logic host_we, host_sel;
	logic [7:0] host_addr, host_data;
	logic mem_req, mem_ack;
	logic [20:0] mem_addr;
	logic [15:0] mem_data;
	logic [5:0] pix_color;
	logic pix_valid;
	logic [8:0] pix_x;

	logic [7:0] sfile [256];	// mirror of the sprite file
	logic cur_valid [line_pixels];	// expected scan of this line
	logic [5:0] cur_color [line_pixels];
	logic nxt_valid [line_pixels];	// drawn now, scanned next line
	logic [5:0] nxt_color [line_pixels];
	int vline = 0;
	int checks = 0;
	int errors = 0;
	int err0;

	// compare stage, driven on falling edges
	logic cmp_en = 1'b0;
	logic [8:0] cmp_x;
	logic got_valid, exp_valid;
	logic [5:0] got_color, exp_color;
	logic [8:0] got_x;

	sprite_unit #(.line_pixels(line_pixels)) DUT (.*);
	sprite_mem_model u_mem (.*);

	initial
		forever
			#4 clk = ~clk;

	// --------------------
	// checking
	a_quiet_req: assert property (@(posedge clk) line_start |-> !mem_req)
		else
		begin
			errors++;
			$display("[ERROR] mem_req expected 0 got %h", mem_req);
		end
	a_quiet_pix: assert property (@(posedge clk) line_start |-> !pix_valid)
		else
		begin
			errors++;
			$display("[ERROR] pix_valid expected 0 got %h", pix_valid);
		end
	a_pix_valid: assert property (@(posedge clk) cmp_en |-> got_valid == exp_valid)
		else
		begin
			errors++;
			$display("[ERROR] pix_valid x=%h expected %h got %h", cmp_x, exp_valid, got_valid);
		end
	a_pix_color: assert property (@(posedge clk) cmp_en && exp_valid |-> got_color == exp_color)
		else
		begin
			errors++;
			$display("[ERROR] pix_color x=%h expected %h got %h", cmp_x, exp_color, got_color);
		end
	a_pix_x: assert property (@(posedge clk) cmp_en |-> got_x == cmp_x)
		else
		begin
			errors++;
			$display("[ERROR] pix_x expected %h got %h", cmp_x, got_x);
		end

	// --------------------
	// reference rules
	function automatic logic [7:0] pal_entry(input int i);
		return 8'(i % 64) | ((i >= 8 && i < 16) ? 8'h80 : 8'h00);	// 8..15 transparent
	endfunction

	function automatic logic [15:0] word_at(input logic [20:0] a);
		return a[15:0] ^ 16'h5a3c;
	endfunction

	task automatic render(input int v);
		int m, y, h, w, x, ppw, px, idx, pb;
		logic [20:0] a;
		logic [15:0] d;
		logic [7:0] b;
		logic [7:0] pe;
		for (int i = 0; i < line_pixels; i++)
			nxt_valid[i] = 1'b0;
		for (int s = 0; s < 32; s++)
		begin
			m = sfile[s*8+4][1:0];
			pb = sfile[s*8+4][7:2];
			y = {sfile[s*8+3][7], sfile[s*8+2]};
			h = sfile[s*8+3][6:0];
			w = sfile[s*8+1][6:0];
			x = {sfile[s*8+1][7], sfile[s*8]};
			a = {sfile[s*8+7][4:0], sfile[s*8+6], sfile[s*8+5]};
			ppw = (m == 1) ? 8 : (m == 2) ? 4 : 2;
			if (m == 0 || v < y || v >= y + h)
				continue;	// off or not on this line
			for (int j = 0; j < w; j++)
			begin
				d = word_at(a + 21'((v - y) * w + j));	// row k at addr + k*width
				for (int p = 0; p < ppw; p++)
				begin
					px = x + j * ppw + p;
					if (px >= line_pixels)
						continue;
					if (m == 3)
					begin
						b = 8'(d >> (8 - 8 * p));	// msb pixel first
						if (b[7])
						begin
							nxt_valid[px] = 1'b1;
							nxt_color[px] = b[5:0];
						end
					end
					else
					begin
						idx = (m == 1) ? pb * 4 + ((d >> (14 - 2 * p)) & 3)
							: (pb >> 2) * 16 + ((d >> (12 - 4 * p)) & 15);
						pe = pal_entry(idx);
						if (!pe[7])
						begin
							nxt_valid[px] = 1'b1;	// later sprites overwrite
							nxt_color[px] = pe[5:0];
						end
					end
				end
			end
		end
	endtask

	// --------------------
	// stimulus
	task automatic write_host(input logic sel, input int addr, input logic [7:0] data);
		host_we = 1'b1;
		host_sel = sel;
		host_addr = 8'(addr);
		host_data = data;
		if (!sel)
			sfile[addr] = data;
		@(negedge clk);
		host_we = 1'b0;
	endtask

	task automatic set_sprite(input int s, x, y, h, w, mode, pbase, input logic [20:0] a);
		write_host(0, s*8, 8'(x));
		write_host(0, s*8+1, {1'(x >> 8), 7'(w)});
		write_host(0, s*8+2, 8'(y));
		write_host(0, s*8+3, {1'(y >> 8), 7'(h)});
		write_host(0, s*8+4, {6'(pbase), 2'(mode)});
		write_host(0, s*8+5, a[7:0]);
		write_host(0, s*8+6, a[15:8]);
		write_host(0, s*8+7, {3'b0, a[20:16]});
	endtask

	task automatic wait_quiet;
		int n;
		n = 0;
		while ((mem_req || mem_ack) && n < 200)	// memory handshake must close
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 200)
		begin
			errors++;
			$display("timeout: memory handshake still open after scan-out");
		end
	endtask

	task automatic run_line(input logic frame);
		line_start = 1'b1;
		frame_start = frame;
		repeat (5) @(negedge clk);
		line_start = 1'b0;
		frame_start = 1'b0;
		vline = frame ? 0 : vline + 1;
		render(vline);
		for (int k = 1; k <= 4 * line_pixels; k++)
		begin
			@(negedge clk);
			cmp_en = 1'b0;
			if (k % 4 == 2)		// middle of pixel k/4
			begin
				cmp_x = 9'(k / 4);
				got_valid = pix_valid;
				got_color = pix_color;
				got_x = pix_x;
				exp_valid = cur_valid[k/4];
				exp_color = cur_color[k/4];
				cmp_en = 1'b1;
				checks++;
			end
		end
		@(negedge clk);
		cmp_en = 1'b0;
		cur_valid = nxt_valid;
		cur_color = nxt_color;
		wait_quiet();
		repeat (60) @(negedge clk);	// line well past 1500 clocks
	endtask

	task automatic end_test(input string name);
		$display("%-26s %s", name, (errors == err0) ? "ok" : "mismatch");
	endtask

	initial
	begin
		line_start = 1'b1;	// engine held idle while loading
		frame_start = 1'b1;
		host_we = 1'b0;
		host_sel = 1'b0;
		host_addr = '0;
		host_data = '0;
		for (int i = 0; i < 256; i++)
			sfile[i] = '0;
		for (int i = 0; i < line_pixels; i++)
		begin
			cur_valid[i] = 1'b0;
			cur_color[i] = '0;
		end
		@(negedge clk);
		for (int i = 0; i < 256; i++)
			write_host(1, i, pal_entry(i));

		err0 = errors;
		run_line(1);
		run_line(0);
		end_test("all sprites off");

		err0 = errors;
		set_sprite(0, 20, 0, 4, 3, 2, 0, 21'h100);
		run_line(1);
		run_line(0);
		end_test("16-colour sprite");

		err0 = errors;
		set_sprite(5, 26, 0, 4, 2, 2, 4, 21'h2000);	// entries 16..31, all opaque
		run_line(1);
		run_line(0);
		end_test("overlap");

		err0 = errors;
		repeat (6) run_line(0);		// rows 1..3, then gone
		end_test("row advance");

		err0 = errors;
		set_sprite(10, 100, 0, 8, 2, 1, 1, 21'h3000);
		set_sprite(11, 340, 0, 8, 20, 3, 0, 21'h1ff00);	// runs past the line end
		run_line(1);
		run_line(0);
		run_line(0);
		end_test("4-colour and true-colour");

		err0 = errors;
		run_line(0);
		run_line(1);
		run_line(0);
		write_host(0, 0*8+4, 8'h00);
		write_host(0, 5*8+4, 8'h00);
		write_host(0, 10*8+4, 8'h00);
		write_host(0, 11*8+4, 8'h00);
		run_line(0);
		run_line(0);
		end_test("frame restart and clear");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
src/spu_pkg.sv
src/spu_ram.sv
src/sprite_line_buffer.sv
src/sprite_fetch.sv
src/sprite_engine.sv
src/sprite_unit.sv
tests/sprite_mem_model.sv
tests/tb_sprite_unit.sv
